// File: compile.f
+incdir+.
mmu_pkg.sv
mmu_if.sv
tlb_cache.sv
page_walker.sv
read_ctrl.sv
mmu_top.sv
mmu_assert.sv
tb_mmu.sv

// File: mmu_assert.sv
// Concurrent checks on the external handshakes of the paging unit
// Bound into mmu_top, watches the memory port and the fault flag
`timescale 1ns/10ps

module mmu_assert import mmu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       rd_reset,
    input logic       rd_page_fault,
    input logic       mem_do,
    input logic       mem_done,
    input phys_addr_t mem_address
);

    // Memory request held with a steady address until answered
    mem_do_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_do && !mem_done |=> mem_do)
        else $error("mem_do dropped before mem_done");

    mem_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_do && !mem_done |=> $stable(mem_address))
        else $error("mem_address changed while the read was pending");

    fault_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        rd_page_fault && !rd_reset |=> rd_page_fault)
        else $error("rd_page_fault cleared without rd_reset");

endmodule

bind mmu_top mmu_assert mmu_assert_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_reset      (rd_reset),
    .rd_page_fault (rd_page_fault),
    .mem_do        (mem_do),
    .mem_done      (mem_done),
    .mem_address   (mem_address)
);

// File: mmu_config.svh
// Build-time constants for the paging unit
// Address and data widths, TLB depth and page-table entry bit positions
// Include this header wherever one of the macros below is referenced
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Bus widths
`define MMU_ADDR_W       32
`define MMU_DATA_W       64

// Translation cache depth, power of two
`define MMU_TLB_ENTRIES  8

// PDE and PTE flag positions
`define MMU_PTE_P        0
`define MMU_PTE_RW       1
`define MMU_PTE_US       2

// Byte length of a single table read
`define MMU_PDE_LEN      4'd4

`endif

// File: mmu_if.sv
// Internal buses of the paging unit
// tlb_if joins the read controller to the translation cache
// walk_if joins the read controller to the page walker
`timescale 1ns/10ps

interface tlb_if import mmu_pkg::*; ();
    // Lookup and fill address, driven by the controller
    linear_addr_t lookup_linear;
    logic         fill_do;
    page_frame_t  fill_frame;
    logic         fill_rw;
    logic         fill_su;
    logic         flush_do;
    // Same-cycle lookup result
    logic         hit;
    page_frame_t  hit_frame;
    logic         hit_rw;
    logic         hit_su;

    modport master (output lookup_linear, fill_do, fill_frame, fill_rw, fill_su, flush_do,
                    input  hit, hit_frame, hit_rw, hit_su);
    modport slave  (input  lookup_linear, fill_do, fill_frame, fill_rw, fill_su, flush_do,
                    output hit, hit_frame, hit_rw, hit_su);
endinterface

interface walk_if import mmu_pkg::*; ();
    logic         start;
    linear_addr_t linear;
    // Walk result, valid with done
    logic         done;
    logic         pde_present;
    logic         pte_present;
    page_frame_t  frame;
    logic         entry_rw;
    logic         entry_su;
    // Table reads, routed through the controller
    logic         mem_do;
    phys_addr_t   mem_addr;
    logic         mem_done;
    mem_data_t    mem_data;

    modport master (output start, linear, mem_done, mem_data,
                    input  done, pde_present, pte_present, frame, entry_rw, entry_su,
                           mem_do, mem_addr);
    modport slave  (input  start, linear, mem_done, mem_data,
                    output done, pde_present, pte_present, frame, entry_rw, entry_su,
                           mem_do, mem_addr);
endinterface

// File: mmu_pkg.sv
// Shared types of the paging unit
// Vector typedefs for addresses, entries and fault codes, plus the
// state encodings of the read controller and the page walker
`include "mmu_config.svh"

package mmu_pkg;

    // Address and data words
    typedef logic [`MMU_ADDR_W-1:0] linear_addr_t;
    typedef logic [`MMU_ADDR_W-1:0] phys_addr_t;
    typedef logic [19:0]            page_frame_t;
    typedef logic [31:0]            pt_entry_t;
    typedef logic [`MMU_DATA_W-1:0] mem_data_t;

    // Bit 0 present, bit 1 write, bit 2 user
    typedef logic [15:0]            err_code_t;
    typedef logic [3:0]             mem_len_t;

    // Read controller FSM
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_WALK,
        CTRL_DATA_REQ,
        CTRL_DATA_WAIT,
        CTRL_FAULT
    } ctrl_state_t;

    // Two-level walker FSM
    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_PDE_WAIT,
        WALK_PTE_REQ,
        WALK_PTE_WAIT
    } walk_state_t;

endpackage

// File: mmu_stim.txt
# M addr data : memory word | C pg wp cr3 : control registers | F : flush all TLB entries
# R addr cpl rmw reads fault err_code phys : read with expected read count and result
M 00001004 0000000000002007
M 00001008 0000000000000000
M 00002004 0000000000005007
M 00002008 0000000000006005
M 0000200c 0000000000007003
M 00002010 0000000000008006
M 00005234 1122334455667788
M 00006010 0badc0de600d0010
C 0 0 00001000
R 00003000 0 0 1 0 0 00003000
C 1 0 00001000
R 00401234 3 0 3 0 0 00005234
R 00401678 3 0 1 0 0 00005678
R 00402010 3 0 3 0 0 00006010
R 00402010 3 1 0 1 7 00000000
R 00402010 0 1 1 0 0 00006010
C 1 1 00001000
R 00402010 0 1 0 1 3 00000000
R 00403020 3 0 2 1 5 00000000
R 00403020 0 1 3 0 0 00007020
R 00404000 3 1 2 1 6 00000000
R 00800000 0 0 1 1 0 00000000
R 00401234 3 0 1 0 0 00005234
F
R 00401234 3 0 3 0 0 00005234

// File: mmu_top.sv
// Top level of the data-read paging unit
// Joins the read controller, translation cache and page walker
// Request side uses a do/done handshake, memory side likewise
`timescale 1ns/10ps

module mmu_top import mmu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    // Control registers
    input  logic         cr0_pg,
    input  logic         cr0_wp,
    input  pt_entry_t    cr3,
    input  logic         flush_all_do,
    // Read request
    input  logic         rd_do,
    input  linear_addr_t rd_address,
    input  logic [1:0]   rd_cpl,
    input  mem_len_t     rd_length,
    input  logic         rd_rmw,
    input  logic         rd_reset,
    output logic         rd_done,
    output mem_data_t    rd_data,
    output logic         rd_page_fault,
    output linear_addr_t pf_cr2,
    output err_code_t    pf_error_code,
    // Memory read port
    output logic         mem_do,
    input  logic         mem_done,
    input  mem_data_t    mem_data,
    output phys_addr_t   mem_address,
    output mem_len_t     mem_length
);

    tlb_if  tlb_bus ();
    walk_if walk_bus ();

    // ------------------------------------------------------------
    // Translation cache and walker
    // ------------------------------------------------------------
    tlb_cache tlb_cache_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .tlb   (tlb_bus.slave)
    );

    page_walker page_walker_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cr3   (cr3),
        .walk  (walk_bus.slave)
    );

    // Sequencer owns the external ports
    read_ctrl read_ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cr0_pg        (cr0_pg),
        .cr0_wp        (cr0_wp),
        .rd_do         (rd_do),
        .rd_address    (rd_address),
        .rd_cpl        (rd_cpl),
        .rd_length     (rd_length),
        .rd_rmw        (rd_rmw),
        .rd_reset      (rd_reset),
        .rd_done       (rd_done),
        .rd_data       (rd_data),
        .rd_page_fault (rd_page_fault),
        .pf_cr2        (pf_cr2),
        .pf_error_code (pf_error_code),
        .mem_do        (mem_do),
        .mem_done      (mem_done),
        .mem_data      (mem_data),
        .mem_address   (mem_address),
        .mem_length    (mem_length),
        .flush_all_do  (flush_all_do),
        .tlb           (tlb_bus.master),
        .walk          (walk_bus.master)
    );

endmodule

// File: page_walker.sv
// Two-level page-table walker
// Reads the PDE at the cr3 frame and then the PTE at the PDE frame
// Stops after the PDE when it is not present
// Results are held from done until the next walk
`timescale 1ns/10ps
`include "mmu_config.svh"

module page_walker import mmu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pt_entry_t cr3,
    walk_if.slave     walk
);

    walk_state_t state;
    pt_entry_t   pde_q;
    pt_entry_t   pte_q;
    logic        done_q;

    // ------------------------------------------------------------
    // Table read requests
    // ------------------------------------------------------------
    // Request held in both wait states, gap in PTE_REQ
    assign walk.mem_do   = (state == WALK_PDE_WAIT) || (state == WALK_PTE_WAIT);
    assign walk.mem_addr = (state == WALK_PDE_WAIT) ?
                           {cr3[31:12], walk.linear[31:22], 2'b00} :
                           {pde_q[31:12], walk.linear[21:12], 2'b00};

    // ------------------------------------------------------------
    // Walk sequence
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= WALK_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                WALK_IDLE: begin
                    if (walk.start) state <= WALK_PDE_WAIT;
                end
                WALK_PDE_WAIT: begin
                    if (walk.mem_done) begin
                        if (walk.mem_data[`MMU_PTE_P]) begin
                            state <= WALK_PTE_REQ;
                        end else begin
                            // Missing directory entry ends the walk early
                            state  <= WALK_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                WALK_PTE_REQ: begin
                    state <= WALK_PTE_WAIT;
                end
                WALK_PTE_WAIT: begin
                    if (walk.mem_done) begin
                        state  <= WALK_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= WALK_IDLE;
            endcase
        end
    end

    // Entry capture, PTE cleared so an early stop reports it absent
    always_ff @(posedge clk) begin
        if (state == WALK_PDE_WAIT && walk.mem_done) begin
            pde_q <= walk.mem_data[31:0];
            pte_q <= '0;
        end
        if (state == WALK_PTE_WAIT && walk.mem_done) begin
            pte_q <= walk.mem_data[31:0];
        end
    end

    // Combined rights are the AND of both levels
    assign walk.done        = done_q;
    assign walk.pde_present = pde_q[`MMU_PTE_P];
    assign walk.pte_present = pte_q[`MMU_PTE_P];
    assign walk.frame       = pte_q[31:12];
    assign walk.entry_rw    = pde_q[`MMU_PTE_RW] & pte_q[`MMU_PTE_RW];
    assign walk.entry_su    = pde_q[`MMU_PTE_US] & pte_q[`MMU_PTE_US];

endmodule

// File: read_ctrl.sv
// Read request sequencer of the paging unit
// Translates through the TLB or a page walk, checks access rights,
// fills the TLB after a clean walk and issues the data read
// Faults park the FSM until rd_reset, with cr2 and error code held
`timescale 1ns/10ps
`include "mmu_config.svh"

module read_ctrl import mmu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cr0_pg,
    input  logic         cr0_wp,
    input  logic         rd_do,
    input  linear_addr_t rd_address,
    input  logic [1:0]   rd_cpl,
    input  mem_len_t     rd_length,
    input  logic         rd_rmw,
    input  logic         rd_reset,
    output logic         rd_done,
    output mem_data_t    rd_data,
    output logic         rd_page_fault,
    output linear_addr_t pf_cr2,
    output err_code_t    pf_error_code,
    output logic         mem_do,
    input  logic         mem_done,
    input  mem_data_t    mem_data,
    output phys_addr_t   mem_address,
    output mem_len_t     mem_length,
    input  logic         flush_all_do,
    tlb_if.master        tlb,
    walk_if.master       walk
);

    ctrl_state_t  state;
    linear_addr_t req_linear;
    mem_len_t     req_len;
    logic         req_su;
    logic         req_rw;
    logic         req_wp;
    logic         req_pg;
    phys_addr_t   phys_q;
    logic         flush_pend;
    logic         hit_fault;
    logic         walk_absent;
    logic         walk_fault;
    logic         fault_set;
    logic         data_phase;

    // User on supervisor page, user write to read-only,
    // supervisor write to read-only under write protect
    function automatic logic prot_fault(input logic su, input logic rw, input logic wp,
                                        input logic e_rw, input logic e_su);
        return (su && !e_su) || (su && e_su && !e_rw && rw) || (wp && !su && !e_rw && rw);
    endfunction

    // ------------------------------------------------------------
    // Translation sources
    // ------------------------------------------------------------
    assign hit_fault   = prot_fault(req_su, req_rw, req_wp, tlb.hit_rw, tlb.hit_su);
    assign walk_absent = !walk.pde_present || !walk.pte_present;
    assign walk_fault  = prot_fault(req_su, req_rw, req_wp, walk.entry_rw, walk.entry_su);
    assign fault_set   = (state == CTRL_LOOKUP && req_pg && tlb.hit && hit_fault) ||
                         (state == CTRL_WALK && walk.done && (walk_absent || walk_fault));

    assign tlb.lookup_linear = req_linear;
    assign tlb.fill_do       = (state == CTRL_WALK) && walk.done && !walk_absent && !walk_fault;
    assign tlb.fill_frame    = walk.frame;
    assign tlb.fill_rw       = walk.entry_rw;
    assign tlb.fill_su       = walk.entry_su;
    // Flushes only land between requests
    assign tlb.flush_do      = (state == CTRL_IDLE) && (flush_all_do || flush_pend);

    assign walk.start    = (state == CTRL_LOOKUP) && req_pg && !tlb.hit;
    assign walk.linear   = req_linear;
    assign walk.mem_done = (state == CTRL_WALK) && mem_done;
    assign walk.mem_data = mem_data;

    // ------------------------------------------------------------
    // Memory port, shared by table reads and the data read
    // ------------------------------------------------------------
    assign data_phase  = (state == CTRL_DATA_REQ) || (state == CTRL_DATA_WAIT);
    assign mem_do      = (state == CTRL_WALK) ? walk.mem_do : data_phase;
    assign mem_address = (state == CTRL_WALK) ? walk.mem_addr : phys_q;
    assign mem_length  = (state == CTRL_WALK) ? `MMU_PDE_LEN : req_len;

    assign rd_done       = data_phase && mem_done;
    assign rd_data       = mem_data;
    assign rd_page_fault = (state == CTRL_FAULT);

    // ------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CTRL_IDLE;
            flush_pend <= 1'b0;
        end else begin
            if (flush_all_do && state != CTRL_IDLE) flush_pend <= 1'b1;
            else if (state == CTRL_IDLE)            flush_pend <= 1'b0;

            case (state)
                CTRL_IDLE: begin
                    if (rd_do) state <= CTRL_LOOKUP;
                end
                CTRL_LOOKUP: begin
                    if (!req_pg)       state <= CTRL_DATA_REQ;
                    else if (!tlb.hit) state <= CTRL_WALK;
                    else if (hit_fault) state <= CTRL_FAULT;
                    else               state <= CTRL_DATA_REQ;
                end
                CTRL_WALK: begin
                    if (walk.done) state <= fault_set ? CTRL_FAULT : CTRL_DATA_REQ;
                end
                CTRL_DATA_REQ: begin
                    state <= mem_done ? CTRL_IDLE : CTRL_DATA_WAIT;
                end
                CTRL_DATA_WAIT: begin
                    if (mem_done) state <= CTRL_IDLE;
                end
                CTRL_FAULT: begin
                    if (rd_reset) state <= CTRL_IDLE;
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // Request, translation and fault payload
    always_ff @(posedge clk) begin
        if (state == CTRL_IDLE && rd_do) begin
            req_linear <= rd_address;
            req_len    <= rd_length;
            req_su     <= (rd_cpl == 2'd3);
            // rmw reads are checked as writes
            req_rw     <= rd_rmw;
            req_wp     <= cr0_wp;
            req_pg     <= cr0_pg;
        end
        if (state == CTRL_LOOKUP) begin
            phys_q <= req_pg ? {tlb.hit_frame, req_linear[11:0]} : req_linear;
        end
        if (state == CTRL_WALK && walk.done) begin
            phys_q <= {walk.frame, req_linear[11:0]};
        end
        if (fault_set) begin
            pf_cr2        <= req_linear;
            // Present bit set only for protection faults
            pf_error_code <= {13'd0, req_su, req_rw, (state == CTRL_LOOKUP) || !walk_absent};
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mmu -f compile.f -o sim_mmu > build.log 2>&1 \
    && ./obj_dir/sim_mmu > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && exit 0 || exit 1

// File: tb_mmu.sv
// Testbench for the data-read paging unit
// Replays control, flush and read records from mmu_stim.txt against a sparse
// memory model that answers after a pseudo-random delay of 1 to 3 cycles
// Checks the logged memory addresses, read data and page-fault reporting
`timescale 1ns/10ps
`include "mmu_config.svh"

module tb_mmu import mmu_pkg::*; ();

    localparam int REQ_TIMEOUT = 200;

    logic         clk;
    logic         rst_n;
    logic         cr0_pg;
    logic         cr0_wp;
    pt_entry_t    cr3;
    logic         flush_all_do;
    logic         rd_do;
    linear_addr_t rd_address;
    logic [1:0]   rd_cpl;
    mem_len_t     rd_length;
    logic         rd_rmw;
    logic         rd_reset;
    logic         rd_done;
    mem_data_t    rd_data;
    logic         rd_page_fault;
    linear_addr_t pf_cr2;
    err_code_t    pf_error_code;
    logic         mem_do;
    logic         mem_done;
    mem_data_t    mem_data;
    phys_addr_t   mem_address;
    mem_len_t     mem_length;

    // Sparse memory image and per-request access log
    mem_data_t    mem_image [phys_addr_t];
    phys_addr_t   addr_log [$];
    mem_len_t     len_log [$];
    logic [31:0]  lcg_state;
    int           errors;
    int           checks;
    int           requests;

    mmu_top mmu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Words not in the image follow an address-derived pattern
    function automatic mem_data_t read_word(input phys_addr_t addr);
        if (mem_image.exists(addr)) return mem_image[addr];
        return {addr ^ 32'hc3a5_96e1, ~addr};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // Memory model, sampled at the falling edge
    // ------------------------------------------------------------
    initial begin : memory_model
        int delay;
        mem_done  = 1'b0;
        mem_data  = '0;
        lcg_state = 32'hac363baf;
        forever begin
            @(negedge clk);
            if (rst_n && mem_do) begin
                addr_log.push_back(mem_address);
                len_log.push_back(mem_length);
                lcg_state = lcg_next(lcg_state);
                delay = 1 + int'(lcg_state[31:16] % 16'd3);
                repeat (delay) @(posedge clk);
                #1;
                mem_done = 1'b1;
                mem_data = read_word(addr_log[$]);
                @(posedge clk);
                #1;
                mem_done = 1'b0;
            end
        end
    end

    task automatic set_control(input logic pg, input logic wp, input pt_entry_t base);
        @(posedge clk);
        #1;
        cr0_pg = pg;
        cr0_wp = wp;
        cr3    = base;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        #1;
        flush_all_do = 1'b1;
        @(posedge clk);
        #1;
        flush_all_do = 1'b0;
    endtask

    // ------------------------------------------------------------
    // One read request and its checks
    // ------------------------------------------------------------
    task automatic run_request(input linear_addr_t addr, input logic [1:0] cpl,
                               input logic rmw, input int exp_reads, input logic exp_fault,
                               input err_code_t exp_err, input phys_addr_t exp_phys);
        int         wait_cycles;
        logic       got_done;
        logic       got_fault;
        logic       walked;
        mem_data_t  got_data;
        mem_data_t  pde_word;
        phys_addr_t pde_addr;
        phys_addr_t pte_addr;
        addr_log.delete();
        len_log.delete();
        got_done    = 1'b0;
        got_fault   = 1'b0;
        got_data    = '0;
        wait_cycles = 0;
        requests++;
        @(posedge clk);
        #1;
        rd_do      = 1'b1;
        rd_address = addr;
        rd_cpl     = cpl;
        rd_rmw     = rmw;
        // Ends on rd_done or the rise of the fault flag
        while (!got_done && !got_fault && wait_cycles < REQ_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
            got_done  = rd_done;
            got_fault = rd_page_fault;
            if (rd_done) got_data = rd_data;
        end
        @(posedge clk);
        #1;
        rd_do = 1'b0;
        if (!got_done && !got_fault) begin
            errors++;
            $display("timeout: read of %h got neither rd_done nor a page fault", addr);
            return;
        end
        check_value("rd_page_fault", 64'(got_fault), 64'(exp_fault));
        check_value("memory read count", 64'(addr_log.size()), 64'(exp_reads));
        // Walk reads come first, PDE then PTE
        walked = (exp_reads == 3) || (exp_fault && exp_reads > 0);
        if (walked && addr_log.size() >= 1) begin
            pde_addr = {cr3[31:12], addr[31:22], 2'b00};
            pde_word = read_word(pde_addr);
            pte_addr = {pde_word[31:12], addr[21:12], 2'b00};
            check_value("mem_address of PDE", 64'(addr_log[0]), 64'(pde_addr));
            check_value("mem_length of PDE", 64'(len_log[0]), 64'(`MMU_PDE_LEN));
            if (exp_reads >= 2 && addr_log.size() >= 2) begin
                check_value("mem_address of PTE", 64'(addr_log[1]), 64'(pte_addr));
                check_value("mem_length of PTE", 64'(len_log[1]), 64'(`MMU_PDE_LEN));
            end
        end
        // Data read is always last
        if (!exp_fault && exp_reads > 0 && addr_log.size() == exp_reads) begin
            check_value("mem_address of data", 64'(addr_log[exp_reads-1]), 64'(exp_phys));
            check_value("mem_length of data", 64'(len_log[exp_reads-1]), 64'(rd_length));
            check_value("rd_data", got_data, read_word(exp_phys));
        end
        if (got_fault) begin
            check_value("pf_cr2", 64'(pf_cr2), 64'(addr));
            check_value("pf_error_code", 64'(pf_error_code), 64'(exp_err));
            // Sticky until rd_reset
            repeat (3) @(negedge clk);
            check_value("rd_page_fault held", 64'(rd_page_fault), 64'(1'b1));
            @(posedge clk);
            #1;
            rd_reset = 1'b1;
            @(posedge clk);
            #1;
            rd_reset = 1'b0;
            @(negedge clk);
            check_value("rd_page_fault after rd_reset", 64'(rd_page_fault), 64'(1'b0));
        end
    endtask

    // ------------------------------------------------------------
    // Record replay
    // ------------------------------------------------------------
    initial begin : stimulus
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [63:0] f [7];
        errors       = 0;
        checks       = 0;
        requests     = 0;
        rst_n        = 1'b0;
        cr0_pg       = 1'b0;
        cr0_wp       = 1'b0;
        cr3          = '0;
        flush_all_do = 1'b0;
        rd_do        = 1'b0;
        rd_address   = '0;
        rd_cpl       = 2'd0;
        rd_length    = 4'd8;
        rd_rmw       = 1'b0;
        rd_reset     = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd = $fopen("mmu_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file mmu_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    // Comment and blank lines fall through the default
                    kind = line.getc(0);
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    case (kind)
                        "M": mem_image[f[0][31:0]] = f[1];
                        "C": set_control(f[0][0], f[1][0], f[2][31:0]);
                        "F": pulse_flush();
                        "R": run_request(f[0][31:0], f[1][1:0], f[2][0], f[3][31:0],
                                         f[4][0], f[5][15:0], f[6][31:0]);
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
        if (requests == 0) begin
            errors++;
            $display("the stimulus file held no read requests");
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tlb_cache.sv
// Fully associative translation cache
// Combinational lookup on the linear page of lookup_linear
// Fills go to a round-robin slot and show up from the next cycle
// A flush drops every entry at the next edge
`timescale 1ns/10ps
`include "mmu_config.svh"

module tlb_cache import mmu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    tlb_if.slave tlb
);

    localparam int IDX_W = $clog2(`MMU_TLB_ENTRIES);

    // Linear page numbers used as tags
    page_frame_t                 tag_q   [`MMU_TLB_ENTRIES];
    page_frame_t                 frame_q [`MMU_TLB_ENTRIES];
    logic [`MMU_TLB_ENTRIES-1:0] rw_q;
    logic [`MMU_TLB_ENTRIES-1:0] su_q;
    logic [`MMU_TLB_ENTRIES-1:0] valid_q;
    logic [IDX_W-1:0]            fill_ptr;
    page_frame_t                 lookup_page;

    assign lookup_page = tlb.lookup_linear[31:12];

    // ------------------------------------------------------------
    // Parallel tag compare
    // ------------------------------------------------------------
    always_comb begin
        tlb.hit       = 1'b0;
        tlb.hit_frame = '0;
        tlb.hit_rw    = 1'b0;
        tlb.hit_su    = 1'b0;
        // At most one entry matches since fills follow a miss
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (valid_q[i] && tag_q[i] == lookup_page) begin
                tlb.hit       = 1'b1;
                tlb.hit_frame = frame_q[i];
                tlb.hit_rw    = rw_q[i];
                tlb.hit_su    = su_q[i];
            end
        end
    end

    // ------------------------------------------------------------
    // Valid bits and replacement pointer
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            fill_ptr <= '0;
        end else if (tlb.flush_do) begin
            valid_q <= '0;
        end else if (tlb.fill_do) begin
            valid_q[fill_ptr] <= 1'b1;
            fill_ptr          <= fill_ptr + 1'b1;
        end
    end

    // Entry contents
    always_ff @(posedge clk) begin
        if (tlb.fill_do) begin
            tag_q[fill_ptr]   <= lookup_page;
            frame_q[fill_ptr] <= tlb.fill_frame;
            rw_q[fill_ptr]    <= tlb.fill_rw;
            su_q[fill_ptr]    <= tlb.fill_su;
        end
    end

endmodule
